// File: logic/aib_ctrl_pkg.sv
/* Shared sizes, types, register map offsets, field positions
   and reset values of the AIB PHY configuration controller */

package aib_ctrl_pkg;

   // ========================================
   // Sizes and types
   // ========================================
   localparam int NCH_DEF = 2;          // Default AIB channel count
   localparam int DLYW    = 10;         // Delay-adjust code width
   localparam int AW      = 12;         // APB address width
   localparam int DW      = 32;         // APB data width

   typedef logic [DLYW-1:0] dly_t;      // One delay-adjust code
   typedef logic [AW-1:0]   addr_t;
   typedef logic [DW-1:0]   data_t;

   // ========================================
   // Register map
   // ========================================
   // Channel region starts at bit 8
   localparam addr_t CHAN_BASE   = 12'h100;
   localparam addr_t CHAN_STRIDE = 12'h010;  // One slot per channel
   localparam addr_t CTRL_OFS    = 12'h000;  // Resets and IDDR enable
   localparam addr_t DLY_OFS     = 12'h004;  // SDR and DDR codes

   // Global and status region
   localparam addr_t GLB_OFS  = 12'h000;     // por_sl2sl, cfg_en
   localparam addr_t STAT_OFS = 12'h004;     // Read only
   localparam addr_t FS_OFS   = 12'h008;     // Far-side resets, read only

   // Field positions
   localparam int DDR_LSB     = 16;          // DDR code in DLY
   localparam int FS_ADAP_LSB = 16;          // fs_adap_rstn in FS

   // ========================================
   // Reset values and misc
   // ========================================
   localparam data_t GLB_RESET = 32'h0000_0001;  // por_sl2sl set, cfg_en clear

   localparam int SYNC_STAGES = 2;  // Flops per synchronizer

endpackage

// File: logic/csr_bus_if.sv
/* Internal register bus between the APB slave and the
   register targets */

interface csr_bus_if;
   import aib_ctrl_pkg::*;

   addr_t addr;     // Offset inside the selected region
   data_t wdata;
   logic  wr_stb;   // One cycle per write
   logic  rd_stb;   // One cycle per read
   data_t rdata;    // Valid the cycle after rd_stb, then held

   // APB side
   modport control (
      output addr,
      output wdata,
      output wr_stb,
      output rd_stb,
      input  rdata
   );

   // Register bank side
   modport target (
      input  addr,
      input  wdata,
      input  wr_stb,
      input  rd_stb,
      output rdata
   );

endinterface

// File: logic/apb_slave_ctrl.sv
/* APB slave with one wait state, region decode and strobe
   generation onto the channel and global register buses */

module apb_slave_ctrl #(
   parameter int NCH = 2
) (
   input  logic                pclk,
   input  logic                rst,
   input  aib_ctrl_pkg::addr_t paddr,
   input  logic                pwrite,
   input  logic                psel,
   input  logic                penable,
   input  aib_ctrl_pkg::data_t pwdata,
   output aib_ctrl_pkg::data_t prdata,
   output logic                pready,
   csr_bus_if.control          chan_bus,
   csr_bus_if.control          glb_bus
);
   import aib_ctrl_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,   // Waiting for setup phase
      S_STB,    // Cycle A, strobe out
      S_DONE    // pready and read data
   } state_t;

   state_t          state_q;
   logic            chan_sel;
   logic            glb_sel;
   logic            sel_chan_q;   // Region of the running transfer
   addr_t           ofs;

   // ========================================
   // Address decode
   // ========================================
   assign chan_sel = |(paddr & CHAN_BASE);           // Bit 8 picks channel region
   assign glb_sel  = !chan_sel;
   assign ofs      = paddr & ~CHAN_BASE;              // Strip the region bit

   // Transfer FSM, psel ignored outside idle
   always_ff @(posedge pclk) begin
      if (rst) begin
         state_q <= S_IDLE;
      end else begin
         case (state_q)
            S_IDLE:  if (psel && !penable) state_q <= S_STB;   // Setup phase seen
            S_STB:   state_q <= S_DONE;
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // Remember region for the read return
   always_ff @(posedge pclk) begin
      if (state_q == S_STB)
         sel_chan_q <= chan_sel;
   end

   // ========================================
   // Register bus drive
   // ========================================
   assign chan_bus.addr   = ofs;
   assign chan_bus.wdata  = pwdata;
   assign chan_bus.wr_stb = (state_q == S_STB) && chan_sel && pwrite;
   assign chan_bus.rd_stb = (state_q == S_STB) && chan_sel && !pwrite;

   assign glb_bus.addr    = ofs;
   assign glb_bus.wdata   = pwdata;
   assign glb_bus.wr_stb  = (state_q == S_STB) && glb_sel && pwrite;
   assign glb_bus.rd_stb  = (state_q == S_STB) && glb_sel && !pwrite;

   // Completion and read return
   assign pready = (state_q == S_DONE);

   always_comb begin
      prdata = '0;                        // Zero outside the done cycle
      if (state_q == S_DONE)
         prdata = sel_chan_q ? chan_bus.rdata : glb_bus.rdata;
   end

endmodule

// File: logic/chan_csr_bank.sv
/* Per-channel CTRL and DLY registers driving the near-side
   resets, IDDR enable and delay-adjust codes */

module chan_csr_bank #(
   parameter int NCH = 2
) (
   input  logic                              pclk,
   input  logic                              rst,
   csr_bus_if.target                         bus,
   output logic [NCH-1:0]                    ns_rstn,
   output logic [NCH-1:0]                    ns_adap_rstn,
   output logic [NCH-1:0]                    iddr_enable,
   output aib_ctrl_pkg::dly_t [NCH-1:0]      sdr_dly,
   output aib_ctrl_pkg::dly_t [NCH-1:0]      ddr_dly
);
   import aib_ctrl_pkg::*;

   localparam int REG_LSB = $clog2(CHAN_STRIDE);
   localparam int IDXW    = $clog2(CHAN_BASE) - REG_LSB;
   localparam int CIW     = (NCH > 1) ? $clog2(NCH) : 1;  // Array select width

   logic [IDXW-1:0] idx;       // Channel slot from offset
   logic [CIW-1:0]  ch;        // Narrowed select
   logic            idx_ok;
   addr_t           reg_ofs;   // Register inside the slot
   data_t           rd_val;

   // ========================================
   // Offset split
   // ========================================
   assign idx     = bus.addr[REG_LSB +: IDXW];
   assign ch      = idx[CIW-1:0];
   assign idx_ok  = (int'(idx) < NCH);
   assign reg_ofs = bus.addr & (CHAN_STRIDE - 1'b1);

   // Control writes, all resets asserted after rst
   always_ff @(posedge pclk) begin
      if (rst) begin
         ns_rstn      <= '0;
         ns_adap_rstn <= '0;
         iddr_enable  <= '0;
         sdr_dly      <= '0;
         ddr_dly      <= '0;
      end else if (bus.wr_stb && idx_ok) begin
         case (reg_ofs)
            CTRL_OFS: begin
               ns_rstn[ch]      <= bus.wdata[0];
               ns_adap_rstn[ch] <= bus.wdata[1];
               iddr_enable[ch]  <= bus.wdata[2];
            end
            DLY_OFS: begin
               sdr_dly[ch] <= bus.wdata[DLYW-1:0];           // Bits 9:0
               ddr_dly[ch] <= bus.wdata[DDR_LSB +: DLYW];    // Bits 25:16
            end
            default: ;   // Unmapped, write dropped
         endcase
      end
   end

   // ========================================
   // Readback
   // ========================================
   always_comb begin
      rd_val = '0;   // Unused bits and slots read zero
      if (idx_ok) begin
         case (reg_ofs)
            CTRL_OFS: rd_val[2:0] = {iddr_enable[ch], ns_adap_rstn[ch], ns_rstn[ch]};
            DLY_OFS: begin
               rd_val[DLYW-1:0]         = sdr_dly[ch];
               rd_val[DDR_LSB +: DLYW]  = ddr_dly[ch];
            end
            default: rd_val = '0;
         endcase
      end
   end

   // Captured on the strobe, held until next read
   always_ff @(posedge pclk) begin
      if (bus.rd_stb)
         bus.rdata <= rd_val;
   end

endmodule

// File: logic/global_status_regs.sv
/* Status synchronizers, global register, status readback,
   digital-domain POR combine and config_done */

module global_status_regs #(
   parameter int NCH = 2
) (
   input  logic           pclk,
   input  logic           rst,
   csr_bus_if.target      bus,
   input  logic [NCH-1:0] rstn_out,        // Far-side returns, async
   input  logic [NCH-1:0] adap_rstn_out,
   input  logic           device_detect,
   input  logic           por_out,
   input  logic           conf_done,
   output logic [NCH-1:0] fs_rstn,
   output logic [NCH-1:0] fs_adap_rstn,
   output logic           por_vcc_dig,
   output logic           config_done
);
   import aib_ctrl_pkg::*;

   localparam int SW = 2*NCH + 3;   // Synchronized bits in total

   logic [SW-1:0] sync_q [SYNC_STAGES];
   logic          dd_s;             // Synchronized device_detect
   logic          por_s;
   logic          conf_s;
   logic [1:0]    glb_q;            // {cfg_en, por_sl2sl}
   data_t         rd_val;

   // ========================================
   // Synchronizers into pclk
   // ========================================
   always_ff @(posedge pclk) begin
      if (rst) begin
         for (int i = 0; i < SYNC_STAGES; i++)
            sync_q[i] <= '0;
      end else begin
         sync_q[0] <= {conf_done, por_out, device_detect, adap_rstn_out, rstn_out};
         for (int i = 1; i < SYNC_STAGES; i++)
            sync_q[i] <= sync_q[i-1];
      end
   end

   assign {conf_s, por_s, dd_s, fs_adap_rstn, fs_rstn} = sync_q[SYNC_STAGES-1];

   // Global register, only writable location here
   always_ff @(posedge pclk) begin
      if (rst)
         glb_q <= GLB_RESET[1:0];
      else if (bus.wr_stb && (bus.addr == GLB_OFS))
         glb_q <= bus.wdata[1:0];
   end

   // ========================================
   // POR and configuration done
   // ========================================
   assign por_vcc_dig = por_out | glb_q[0];   // Raw POR, no sync on this path

   always_ff @(posedge pclk) begin
      if (rst)
         config_done <= 1'b0;
      else
         config_done <= glb_q[1] & conf_s & ~por_s;  // Enabled, configured, out of POR
   end

   // Readback decode
   always_comb begin
      rd_val = '0;
      case (bus.addr)
         GLB_OFS:  rd_val[1:0] = glb_q;
         STAT_OFS: rd_val[2:0] = {conf_s, por_s, dd_s};
         FS_OFS: begin
            rd_val[NCH-1:0]            = fs_rstn;
            rd_val[FS_ADAP_LSB +: NCH] = fs_adap_rstn;
         end
         default:  rd_val = '0;   // Unmapped
      endcase
   end

   always_ff @(posedge pclk) begin
      if (bus.rd_stb)
         bus.rdata <= rd_val;
   end

endmodule

// File: logic/aib_phy_ctrl.sv
/* Top level of the AIB PHY configuration controller
   with APB slave, channel registers and global status */

module aib_phy_ctrl #(
   parameter int NCH = aib_ctrl_pkg::NCH_DEF
) (
   input  logic                         pclk,
   input  logic                         rst,
   // APB
   input  aib_ctrl_pkg::addr_t          paddr,
   input  logic                         pwrite,
   input  logic                         psel,
   input  logic                         penable,
   input  aib_ctrl_pkg::data_t          pwdata,
   output aib_ctrl_pkg::data_t          prdata,
   output logic                         pready,
   // Near-side controls
   output logic [NCH-1:0]               r_apb_ns_rstn,
   output logic [NCH-1:0]               r_apb_ns_adap_rstn,
   output logic [NCH-1:0]               r_apb_iddr_enable,
   output aib_ctrl_pkg::dly_t [NCH-1:0] sdr_dly_adjust,
   output aib_ctrl_pkg::dly_t [NCH-1:0] ddr_dly_adjust,
   // Far side returns
   input  logic [NCH-1:0]               rstn_out,
   input  logic [NCH-1:0]               adap_rstn_out,
   output logic [NCH-1:0]               r_apb_fs_rstn,
   output logic [NCH-1:0]               r_apb_fs_adap_rstn,
   // POR and configuration
   input  logic                         device_detect,
   input  logic                         por_out,
   input  logic                         conf_done,
   output logic                         por_vcc_dig,    // VCC_DIG domain POR
   output logic                         config_done     // To open drain driver
);

   csr_bus_if chan_bus ();   // Channel region 0x100
   csr_bus_if glb_bus  ();   // Global and status region

   apb_slave_ctrl #(.NCH(NCH)) u_apb (
      .pclk     (pclk),
      .rst      (rst),
      .paddr    (paddr),
      .pwrite   (pwrite),
      .psel     (psel),
      .penable  (penable),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .chan_bus (chan_bus.control),
      .glb_bus  (glb_bus.control)
   );

   chan_csr_bank #(.NCH(NCH)) u_chan (
      .pclk         (pclk),
      .rst          (rst),
      .bus          (chan_bus.target),
      .ns_rstn      (r_apb_ns_rstn),
      .ns_adap_rstn (r_apb_ns_adap_rstn),
      .iddr_enable  (r_apb_iddr_enable),
      .sdr_dly      (sdr_dly_adjust),
      .ddr_dly      (ddr_dly_adjust)
   );

   global_status_regs #(.NCH(NCH)) u_glb (
      .pclk          (pclk),
      .rst           (rst),
      .bus           (glb_bus.target),
      .rstn_out      (rstn_out),
      .adap_rstn_out (adap_rstn_out),
      .device_detect (device_detect),
      .por_out       (por_out),
      .conf_done     (conf_done),
      .fs_rstn       (r_apb_fs_rstn),
      .fs_adap_rstn  (r_apb_fs_adap_rstn),
      .por_vcc_dig   (por_vcc_dig),
      .config_done   (config_done)
   );

endmodule

// File: bench/tb_apb_tasks.svh
/* APB transfer tasks, LCG random source, value check
   and per-test report helpers for the testbench */

`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

logic [31:0] lcg_state = 32'd10699;   // Fixed seed

// Next LCG value, full 32 bits
function automatic data_t lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Blocks until pready is seen between clock edges
task automatic wait_ready();
   @(negedge pclk);
   while (!pready) @(negedge pclk);
endtask

// One APB transfer, setup then access phase
task automatic apb_xfer(input logic wr, input addr_t addr, input data_t wdata,
                        output data_t rdata);
   @(posedge pclk);
   paddr   <= addr;
   pwrite  <= wr;
   pwdata  <= wdata;
   psel    <= 1'b1;
   penable <= 1'b0;
   @(posedge pclk);
   penable <= 1'b1;   // Cycle A
   wait_ready();
   rdata = prdata;    // Sampled with pready
   @(posedge pclk);
   psel    <= 1'b0;
   penable <= 1'b0;
endtask

task automatic check_eq(input string name, input data_t got, input data_t exp);
   checks++;
   assert (got === exp) else begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
   end
endtask

task automatic write_reg(input addr_t addr, input data_t data);
   data_t unused;
   apb_xfer(1'b1, addr, data, unused);
endtask

task automatic read_expect(input addr_t addr, input data_t exp, input string name);
   data_t got;
   apb_xfer(1'b0, addr, '0, got);
   check_eq(name, got, exp);
endtask

// One line per finished test
task automatic report_test(input string name, input int mark);
   if (errors == mark)
      $display("Test %s: ok", name);
   else
      $display("Test %s: %0d errors", name, errors - mark);
endtask

`endif

// File: bench/tb_aib_phy_ctrl.sv
/* Testbench for the AIB PHY configuration controller with
   clock, reset, watchdog, APB stimulus and assertions */

module tb_aib_phy_ctrl;
   import aib_ctrl_pkg::*;

   localparam int NCH        = NCH_DEF;
   localparam int CLK_PERIOD = 40;
   localparam int ROUNDS     = 4;   // Random passes per test
   // Transfers per test, sizes the watchdog
   localparam int N_XFER = 5 + (NCH * ROUNDS * 4 + 1) + 4 + ROUNDS * 2 + 4;

   logic               pclk = 1'b0;
   logic               rst;
   addr_t              paddr;
   logic               pwrite;
   logic               psel;
   logic               penable;
   data_t              pwdata;
   data_t              prdata;
   logic               pready;
   logic [NCH-1:0]     r_apb_ns_rstn;
   logic [NCH-1:0]     r_apb_ns_adap_rstn;
   logic [NCH-1:0]     r_apb_iddr_enable;
   dly_t [NCH-1:0]     sdr_dly_adjust;
   dly_t [NCH-1:0]     ddr_dly_adjust;
   logic [NCH-1:0]     rstn_out;
   logic [NCH-1:0]     adap_rstn_out;
   logic [NCH-1:0]     r_apb_fs_rstn;
   logic [NCH-1:0]     r_apb_fs_adap_rstn;
   logic               device_detect;
   logic               por_out;
   logic               conf_done;
   logic               por_vcc_dig;
   logic               config_done;

   int                 checks = 0;
   int                 errors = 0;
   int                 err_mark;
   logic               sl2sl_exp = 1'b1;   // GLB bit 0 model
   logic               cfg_exp = 1'b0;     // GLB bit 1 model
   logic [2:0]         ctrl_exp [NCH];
   dly_t               sdr_exp [NCH];
   dly_t               ddr_exp [NCH];
   data_t              rnd;

   `include "tb_apb_tasks.svh"

   aib_phy_ctrl #(.NCH(NCH)) dut0 (.*);

   always #(CLK_PERIOD / 2) pclk = ~pclk;

   function automatic addr_t chan_addr(input int ch, input addr_t ofs);
      return CHAN_BASE + addr_t'(ch) * CHAN_STRIDE + ofs;
   endfunction

   // ========================================
   // Assertions
   // ========================================
   assert property (@(posedge pclk) disable iff (rst) $rose(penable) |-> !pready)
      else begin
         errors++;
         $display("pready was high in the first enable cycle");
      end
   assert property (@(posedge pclk) disable iff (rst) $rose(penable) |=> pready)
      else begin
         errors++;
         $display("pready missing one cycle after the first enable");
      end
   assert property (@(posedge pclk) disable iff (rst) pready |=> !pready)
      else begin
         errors++;
         $display("pready stayed high for two cycles");
      end

   // POR combine, outside transfers so the GLB model is current
   always @(negedge pclk) begin
      if (!rst && !psel)
         check_eq("por_vcc_dig", data_t'(por_vcc_dig), data_t'(por_out | sl2sl_exp));
   end

   initial begin
      #(CLK_PERIOD * (200 + 10 * N_XFER));
      $display("Watchdog expired before the tests finished");
      $display("Regression failed");
      $finish;
   end

   // Near-side outputs of every channel against the model
   task automatic check_chan_outputs();
      for (int c = 0; c < NCH; c++) begin
         check_eq($sformatf("r_apb_ns_rstn[%0d]", c), data_t'(r_apb_ns_rstn[c]),
                  data_t'(ctrl_exp[c][0]));
         check_eq($sformatf("r_apb_ns_adap_rstn[%0d]", c), data_t'(r_apb_ns_adap_rstn[c]),
                  data_t'(ctrl_exp[c][1]));
         check_eq($sformatf("r_apb_iddr_enable[%0d]", c), data_t'(r_apb_iddr_enable[c]),
                  data_t'(ctrl_exp[c][2]));
         check_eq($sformatf("sdr_dly_adjust[%0d]", c), data_t'(sdr_dly_adjust[c]),
                  data_t'(sdr_exp[c]));
         check_eq($sformatf("ddr_dly_adjust[%0d]", c), data_t'(ddr_dly_adjust[c]),
                  data_t'(ddr_exp[c]));
      end
   endtask

   // Walks conf_done and por_out through all four pairs
   task automatic run_por_combos();
      for (int i = 0; i < 4; i++) begin
         @(posedge pclk);
         conf_done <= i[0];
         por_out   <= i[1];
         repeat (3) @(posedge pclk);   // Sync plus output flop
         @(negedge pclk);
         check_eq("config_done", data_t'(config_done), data_t'(cfg_exp & i[0] & !i[1]));
      end
   endtask

   initial begin
      rst           <= 1'b1;
      paddr         <= '0;
      pwrite        <= 1'b0;
      psel          <= 1'b0;
      penable       <= 1'b0;
      pwdata        <= '0;
      rstn_out      <= '0;
      adap_rstn_out <= '0;
      device_detect <= 1'b0;
      por_out       <= 1'b0;
      conf_done     <= 1'b0;
      for (int c = 0; c < NCH; c++) begin
         ctrl_exp[c] = '0;
         sdr_exp[c]  = '0;
         ddr_exp[c]  = '0;
      end
      repeat (2) @(posedge pclk);
      rst <= 1'b0;

      // ========================================
      // Reset values
      // ========================================
      err_mark = errors;
      @(negedge pclk);
      check_eq("pready", data_t'(pready), '0);
      check_chan_outputs();
      check_eq("config_done", data_t'(config_done), '0);
      read_expect(GLB_OFS, GLB_RESET, "prdata GLB");
      for (int c = 0; c < NCH; c++) begin
         read_expect(chan_addr(c, CTRL_OFS), '0, $sformatf("prdata CTRL[%0d]", c));
         read_expect(chan_addr(c, DLY_OFS), '0, $sformatf("prdata DLY[%0d]", c));
      end
      report_test("reset values", err_mark);

      // Channel registers, random data
      err_mark = errors;
      for (int c = 0; c < NCH; c++) begin
         for (int r = 0; r < ROUNDS; r++) begin
            rnd = lcg_next();
            ctrl_exp[c] = rnd[2:0];
            write_reg(chan_addr(c, CTRL_OFS), rnd);
            rnd = lcg_next();
            sdr_exp[c] = rnd[9:0];
            ddr_exp[c] = rnd[25:16];
            write_reg(chan_addr(c, DLY_OFS), rnd);
            @(negedge pclk);
            check_chan_outputs();
            read_expect(chan_addr(c, CTRL_OFS), data_t'(ctrl_exp[c]),
                        $sformatf("prdata CTRL[%0d]", c));
            read_expect(chan_addr(c, DLY_OFS), {6'b0, ddr_exp[c], 6'b0, sdr_exp[c]},
                        $sformatf("prdata DLY[%0d]", c));
         end
      end
      read_expect(chan_addr(3, CTRL_OFS), '0, "prdata CTRL[3]");   // No such channel
      report_test("channel registers", err_mark);

      // Back to back transfers, timing checked by the properties
      err_mark = errors;
      write_reg(GLB_OFS, GLB_RESET);
      read_expect(GLB_OFS, GLB_RESET, "prdata GLB");
      read_expect(STAT_OFS, '0, "prdata STAT");
      read_expect(FS_OFS, '0, "prdata FS");
      report_test("APB timing", err_mark);

      // ========================================
      // Status synchronization
      // ========================================
      err_mark = errors;
      for (int r = 0; r < ROUNDS; r++) begin
         rnd = lcg_next();
         @(posedge pclk);
         rstn_out      <= rnd[NCH-1:0];
         adap_rstn_out <= rnd[8 +: NCH];
         device_detect <= rnd[16];
         por_out       <= rnd[17];
         conf_done     <= rnd[18];
         repeat (3) @(posedge pclk);
         @(negedge pclk);
         check_eq("r_apb_fs_rstn", data_t'(r_apb_fs_rstn), data_t'(rnd[NCH-1:0]));
         check_eq("r_apb_fs_adap_rstn", data_t'(r_apb_fs_adap_rstn), data_t'(rnd[8 +: NCH]));
         read_expect(FS_OFS, (data_t'(rnd[8 +: NCH]) << 16) | data_t'(rnd[NCH-1:0]),
                     "prdata FS");
         read_expect(STAT_OFS, data_t'(rnd[18:16]), "prdata STAT");   // conf, por, detect
      end
      report_test("status synchronization", err_mark);

      // POR combine and config_done
      err_mark = errors;
      write_reg(GLB_OFS, 32'h3);
      cfg_exp = 1'b1;
      run_por_combos();
      write_reg(GLB_OFS, 32'h2);   // por_sl2sl cleared
      sl2sl_exp = 1'b0;
      run_por_combos();
      write_reg(GLB_OFS, 32'h0);
      cfg_exp = 1'b0;
      run_por_combos();
      read_expect(GLB_OFS, '0, "prdata GLB");
      report_test("POR and config_done", err_mark);

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// File: project.f
+incdir+bench
logic/aib_ctrl_pkg.sv
logic/csr_bus_if.sv
logic/apb_slave_ctrl.sv
logic/chan_csr_bank.sv
logic/global_status_regs.sv
logic/aib_phy_ctrl.sv
bench/tb_aib_phy_ctrl.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass decided from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_aib_phy_ctrl \
   -f project.f -o sim_tb \
   && ./obj_dir/sim_tb | tee sim.log \
   && grep -qx "Regression passed" sim.log \
   || { echo "Simulation did not pass"; exit 1; }
echo "Simulation passed"
